//--- core_top.f
hdl/core_pkg.sv
hdl/ifu.sv
hdl/idu.sv
hdl/exu.sv
hdl/lsu.sv
hdl/wbu.sv
hdl/core_top.sv
verification/core_top_properties.sv
verification/core_top_tb.sv

//--- Bender.yml
package:
  name: core_top

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/ifu.sv
      - hdl/idu.sv
      - hdl/exu.sv
      - hdl/lsu.sv
      - hdl/wbu.sv
      - hdl/core_top.sv
  - target: test
    files:
      - verification/core_top_properties.sv
      - verification/core_top_tb.sv

//--- verification/core_top_tb.sv
`timescale 1ns/1ns

module core_top_tb;

    localparam int N_INST  = 200;
    localparam int N_DW    = 32;
    localparam int TIMEOUT = 5000;
    localparam int IDLE    = 200;

    localparam logic [2:0] K_OP  = 3'd0;
    localparam logic [2:0] K_IMM = 3'd1;
    localparam logic [2:0] K_LUI = 3'd2;
    localparam logic [2:0] K_LD  = 3'd3;
    localparam logic [2:0] K_SD  = 3'd4;
    localparam logic [2:0] K_BR  = 3'd5;
    localparam logic [2:0] K_JAL = 3'd6;

    // program slot where alt selects sub for OP and ne for branches
    typedef struct packed {
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] imm;
    } entry_t;

    logic                clk;
    logic                rst_n;
    logic                ifu_arready;
    logic                ifu_arvalid;
    logic [63:0]         ifu_araddr;
    logic                ifu_rvalid;
    logic                ifu_rready;
    logic [31:0]         ifu_rdata;
    logic                lsu_req_valid;
    logic                lsu_req_ready;
    core_pkg::data_req_t lsu_req;
    logic                lsu_rsp_valid;
    logic [63:0]         lsu_rsp_rdata;

    entry_t              ent [N_INST];
    core_pkg::inst_t     prog [N_INST];
    logic [63:0]         dmem [N_DW];
    core_pkg::data_req_t exp_q [$];
    logic [31:0]         rng;
    logic [31:0]         rng_f;
    logic [31:0]         rng_d;
    logic                fetched;
    int                  n_seen;

    core_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // a bound assertion failure ends the run
    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0) end_on_assertion();
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic int unsigned rnd_below(input int unsigned n);
        rng = xorshift(rng);
        return rng % n;
    endfunction

    // depends on every bit of the byte address
    function automatic logic [63:0] fill_word(input int k);
        logic [31:0] a;
        a = k * 8;
        return {a ^ 32'hc3a5_5a3c, ~a + 32'h1357_9bdf};
    endfunction

    function automatic logic [63:0] alu(input logic [2:0] f3, input logic sub,
                                       input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] pick_f3();
        case (rnd_below(4))
            0:       return 3'b000;
            1:       return 3'b100;
            2:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] encode(input entry_t e);
        case (e.kind)
            K_OP:    return {1'b0, e.alt, 5'd0, e.rs2, e.rs1, e.f3, e.rd, core_pkg::OPC_OP};
            K_IMM:   return {e.imm[11:0], e.rs1, e.f3, e.rd, core_pkg::OPC_OP_IMM};
            K_LUI:   return {e.imm[31:12], e.rd, core_pkg::OPC_LUI};
            K_LD:    return {e.imm[11:0], e.rs1, 3'b011, e.rd, core_pkg::OPC_LOAD};
            K_SD:    return {e.imm[11:5], e.rs2, e.rs1, 3'b011, e.imm[4:0],
                             core_pkg::OPC_STORE};
            K_BR:    return {e.imm[12], e.imm[10:5], e.rs2, e.rs1, 2'b00, e.alt, e.imm[4:1],
                             e.imm[11], core_pkg::OPC_BRANCH};
            default: return {e.imm[20], e.imm[10:1], e.imm[11], e.imm[19:12], e.rd,
                             core_pkg::OPC_JAL};
        endcase
    endfunction

    task automatic build_program();
        entry_t      e;
        int          i;
        int          span;
        logic [19:0] u;
        i = 0;
        while (i < N_INST - 1) begin
            e      = '0;
            e.kind = 3'(rnd_below(7));
            e.rd   = 5'(rnd_below(8));
            e.rs1  = 5'(rnd_below(8));
            e.rs2  = 5'(rnd_below(8));
            span   = (N_INST - 1 - i < 8) ? N_INST - 1 - i : 8;
            case (e.kind)
                K_OP: begin
                    e.f3  = pick_f3();
                    e.alt = (e.f3 == 3'b000) && (rnd_below(2) == 1);
                end
                K_IMM: begin
                    e.f3  = pick_f3();
                    e.imm = 64'(rnd_below(4096)) - 64'd2048;
                end
                K_LUI: begin
                    u     = 20'(rnd_below(1 << 20));
                    e.imm = {{32{u[19]}}, u, 12'h0};
                end
                K_LD, K_SD: begin
                    e.rs1 = 5'd0;
                    e.imm = 64'(8 * rnd_below(N_DW));
                end
                K_BR: begin
                    e.alt = rnd_below(2) == 1;
                    e.imm = 64'(4 * (1 + rnd_below(span)));
                end
                default: e.imm = 64'(4 * (1 + rnd_below(span)));
            endcase
            ent[i]  = e;
            prog[i] = encode(e);
            i++;
            // store the loaded register right after the load
            if (e.kind == K_LD && i < N_INST - 1 && rnd_below(2) == 1) begin
                e.kind  = K_SD;
                e.rs2   = e.rd;
                e.imm   = 64'(8 * rnd_below(N_DW));
                ent[i]  = e;
                prog[i] = encode(e);
                i++;
            end
        end
        // jump to itself
        e                = '0;
        e.kind           = K_JAL;
        ent[N_INST - 1]  = e;
        prog[N_INST - 1] = encode(e);
    endtask

    task automatic run_model();
        logic [63:0]         x [32];
        logic [63:0]         mem [N_DW];
        logic [63:0]         res;
        entry_t              e;
        core_pkg::data_req_t r;
        int                  pc;
        int                  next;
        int                  k;
        for (k = 0; k < 32; k++) x[k] = '0;
        for (k = 0; k < N_DW; k++) mem[k] = fill_word(k);
        pc = 0;
        while (pc != N_INST - 1) begin
            e    = ent[pc];
            next = pc + 1;
            res  = '0;
            case (e.kind)
                K_OP:  res = alu(e.f3, e.alt, x[e.rs1], x[e.rs2]);
                K_IMM: res = alu(e.f3, 1'b0, x[e.rs1], e.imm);
                K_LUI: res = e.imm;
                K_LD: begin
                    res = mem[e.imm[7:3]];
                    r   = '{addr: e.imm, wdata: '0, write: 1'b0};
                    exp_q.push_back(r);
                end
                K_SD: begin
                    mem[e.imm[7:3]] = x[e.rs2];
                    r = '{addr: e.imm, wdata: x[e.rs2], write: 1'b1};
                    exp_q.push_back(r);
                end
                K_BR: if ((x[e.rs1] == x[e.rs2]) != e.alt) next = pc + int'(e.imm[12:2]);
                default: begin
                    res  = 64'(pc * 4 + 4);
                    next = pc + int'(e.imm[12:2]);
                end
            endcase
            if (e.kind != K_SD && e.kind != K_BR && e.rd != 5'd0) x[e.rd] = res;
            pc = next;
        end
    endtask

    task automatic flag_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_wait(input string what);
        $display("Timed out waiting for %s", what);
        $display("Finished with errors");
        $fatal(1, "stopped on a timeout");
    endtask

    task automatic end_on_assertion();
        $display("A bus protocol assertion failed");
        $display("Finished with errors");
        $fatal(1, "stopped on an assertion failure");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic random_delay(inout logic [31:0] s);
        s = xorshift(s);
        repeat (s % 3) next_cycle();
    endtask

    task automatic serve_fetch();
        logic [63:0] addr;
        int          t;
        t = 0;
        while (!ifu_arvalid) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) abort_wait("an instruction fetch");
        end
        random_delay(rng_f);
        ifu_arready = 1'b1;
        addr        = ifu_araddr;
        next_cycle();
        ifu_arready = 1'b0;
        random_delay(rng_f);
        ifu_rvalid = 1'b1;
        // past the last slot the core only sees bubbles
        if (addr < N_INST * 4) ifu_rdata = prog[addr[9:2]];
        else ifu_rdata = 32'h0;
        t = 0;
        while (!ifu_rready) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) abort_wait("ifu_rready");
        end
        next_cycle();
        fetched    = 1'b1;
        ifu_rvalid = 1'b0;
    endtask

    task automatic serve_data();
        core_pkg::data_req_t req;
        core_pkg::data_req_t want;
        int                  t;
        t = 0;
        while (!lsu_req_valid) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) abort_wait("a data request");
        end
        assert (fetched) else flag_mismatch("data request before any fetch completed");
        random_delay(rng_d);
        lsu_req_ready = 1'b1;
        req           = lsu_req;
        next_cycle();
        lsu_req_ready = 1'b0;
        want = exp_q.pop_front();
        n_seen++;
        assert (req.addr == want.addr && req.write == want.write &&
                (!want.write || req.wdata == want.wdata))
            else flag_mismatch($sformatf("request %0d: %h %b %h, model %h %b %h", n_seen,
                               req.addr, req.write, req.wdata,
                               want.addr, want.write, want.wdata));
        random_delay(rng_d);
        lsu_rsp_valid = 1'b1;
        lsu_rsp_rdata = dmem[req.addr[7:3]];
        if (req.write) dmem[req.addr[7:3]] = req.wdata;
        next_cycle();
        lsu_rsp_valid = 1'b0;
    endtask

    initial begin
        int t;
        rst_n         = 1'b0;
        ifu_arready   = 1'b0;
        ifu_rvalid    = 1'b0;
        ifu_rdata     = 32'h0;
        lsu_req_ready = 1'b0;
        lsu_rsp_valid = 1'b0;
        lsu_rsp_rdata = 64'h0;
        rng           = 32'h6926_7c26;
        rng_f         = rng ^ 32'h0000_ffff;
        rng_d         = rng ^ 32'hffff_0000;
        fetched       = 1'b0;
        n_seen        = 0;
        for (t = 0; t < N_DW; t++) dmem[t] = fill_word(t);
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        t = 0;
        while (!ifu_arvalid) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) abort_wait("the first fetch");
        end
        assert (ifu_araddr == core_pkg::RST_PC)
            else flag_mismatch($sformatf("first fetch address %h", ifu_araddr));
        fork
            forever serve_fetch();
        join_none
        while (exp_q.size() > 0) serve_data();
        // the self loop must stay quiet on the data port
        repeat (IDLE) begin
            next_cycle();
            assert (!lsu_req_valid) else flag_mismatch("data request beyond the model's list");
        end
        if (i_dut.i_props.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            end_on_assertion();
        end
    end

endmodule

//--- verification/core_top_properties.sv
`timescale 1ns/1ns

module core_top_properties (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      ifu_arvalid,
    input logic                      ifu_arready,
    input logic [core_pkg::XLEN-1:0] ifu_araddr,
    input logic                      lsu_req_valid,
    input logic                      lsu_req_ready,
    input core_pkg::data_req_t       lsu_req
);

    int fail_count = 0;

    // fetch address held until taken
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ifu_arvalid && !ifu_arready |=> ifu_arvalid && $stable(ifu_araddr))
        else begin
            $error("ifu_arvalid dropped or ifu_araddr changed before ifu_arready");
            fail_count++;
        end

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req_valid && !lsu_req_ready |=> lsu_req_valid && $stable(lsu_req))
        else begin
            $error("lsu_req_valid dropped or lsu_req changed before lsu_req_ready");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !ifu_arvalid && !lsu_req_valid)
        else begin
            $error("bus valid high during reset");
            fail_count++;
        end

endmodule

bind core_top core_top_properties i_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .ifu_arvalid   (ifu_arvalid),
    .ifu_arready   (ifu_arready),
    .ifu_araddr    (ifu_araddr),
    .lsu_req_valid (lsu_req_valid),
    .lsu_req_ready (lsu_req_ready),
    .lsu_req       (lsu_req)
);

//--- hdl/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ifu_arready,
    output logic                      ifu_arvalid,
    output logic [core_pkg::XLEN-1:0] ifu_araddr,
    input  logic                      ifu_rvalid,
    output logic                      ifu_rready,
    input  logic [31:0]               ifu_rdata,
    output logic                      lsu_req_valid,
    input  logic                      lsu_req_ready,
    output core_pkg::data_req_t       lsu_req,
    input  logic                      lsu_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] lsu_rsp_rdata
);

    logic                        redirect;
    logic [core_pkg::XLEN-1:0]   redirect_pc;
    logic                        if_id_valid;
    logic                        if_id_ready;
    core_pkg::if_id_t            if_id;
    logic                        id_ex_valid;
    logic                        id_ex_ready;
    core_pkg::id_ex_t            id_ex;
    logic                        ex_ls_valid;
    logic                        ex_ls_ready;
    core_pkg::ex_ls_t            ex_ls;
    logic                        ls_wb_valid;
    core_pkg::ls_wb_t            ls_wb;
    logic [core_pkg::REG_AW-1:0] rs1;
    logic [core_pkg::REG_AW-1:0] rs2;
    logic [core_pkg::XLEN-1:0]   src1;
    logic [core_pkg::XLEN-1:0]   src2;
    core_pkg::busy_rd_t          ex_busy_rd;
    core_pkg::busy_rd_t          ls_busy_rd;
    core_pkg::busy_rd_t          wb_busy_rd;

    // hazard view of EX/LS and LS/WB
    assign ex_busy_rd = '{valid: ex_ls_valid, wen: ex_ls.rd_wen, rd: ex_ls.rd};
    assign wb_busy_rd = '{valid: ls_wb_valid, wen: ls_wb.rd_wen, rd: ls_wb.rd};

    ifu u_ifu (.*);

    idu u_idu (.*, .flush(redirect));

    exu u_exu (.*);

    lsu u_lsu (.*);

    wbu u_wbu (.*);

endmodule

//--- hdl/wbu.sv
`timescale 1ns/1ns

module wbu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [core_pkg::REG_AW-1:0] rs1,
    input  logic [core_pkg::REG_AW-1:0] rs2,
    output logic [core_pkg::XLEN-1:0]   src1,
    output logic [core_pkg::XLEN-1:0]   src2,
    input  logic                        ls_wb_valid,
    input  core_pkg::ls_wb_t            ls_wb
);

    localparam int NREGS = 1 << core_pkg::REG_AW;

    logic [core_pkg::XLEN-1:0] regs [NREGS];
    logic [NREGS-1:0]          written;
    logic                      wen;

    // x0 is never marked written
    assign wen = ls_wb_valid & ls_wb.rd_wen & (ls_wb.rd != '0);

    // unwritten registers read as zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) written <= '0;
        else if (wen) written[ls_wb.rd] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wen) regs[ls_wb.rd] <= ls_wb.data;
    end

    assign src1 = written[rs1] ? regs[rs1] : '0;
    assign src2 = written[rs2] ? regs[rs2] : '0;

endmodule

//--- hdl/lsu.sv
`timescale 1ns/1ns

module lsu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_ls_valid,
    output logic                      ex_ls_ready,
    input  core_pkg::ex_ls_t          ex_ls,
    output logic                      lsu_req_valid,
    input  logic                      lsu_req_ready,
    output core_pkg::data_req_t       lsu_req,
    input  logic                      lsu_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] lsu_rsp_rdata,
    output core_pkg::busy_rd_t        ls_busy_rd,
    output logic                      ls_wb_valid,
    output core_pkg::ls_wb_t          ls_wb
);

    logic busy;
    logic accept;
    logic is_mem;

    // ready only between memory operations
    assign ex_ls_ready = ~busy;
    assign accept      = ex_ls_valid & ex_ls_ready;
    assign is_mem      = ex_ls.is_load | ex_ls.is_store;
    // LS/WB already holds the destination of the pending op
    assign ls_busy_rd  = '{valid: busy, wen: ls_wb.rd_wen, rd: ls_wb.rd};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            lsu_req_valid <= 1'b0;
            ls_wb_valid   <= 1'b0;
        end else begin
            ls_wb_valid <= (accept & ~is_mem) | (busy & lsu_rsp_valid);
            if (accept && is_mem) begin
                busy          <= 1'b1;
                lsu_req_valid <= 1'b1;
            end else if (lsu_rsp_valid) begin
                busy <= 1'b0;
            end
            if (lsu_req_valid && lsu_req_ready) lsu_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lsu_req.addr  <= ex_ls.result;
            lsu_req.wdata <= ex_ls.store_data;
            lsu_req.write <= ex_ls.is_store;
            ls_wb.rd      <= ex_ls.rd;
            ls_wb.rd_wen  <= ex_ls.rd_wen;
            ls_wb.data    <= ex_ls.result;
        end else if (busy && lsu_rsp_valid) begin
            ls_wb.data <= lsu_rsp_rdata;
        end
    end

endmodule

//--- hdl/exu.sv
`timescale 1ns/1ns

module exu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      id_ex_valid,
    output logic                      id_ex_ready,
    input  core_pkg::id_ex_t          id_ex,
    output logic                      redirect,
    output logic [core_pkg::XLEN-1:0] redirect_pc,
    output logic                      ex_ls_valid,
    input  logic                      ex_ls_ready,
    output core_pkg::ex_ls_t          ex_ls
);

    logic [core_pkg::XLEN-1:0] alu_res;
    logic                      accept;
    logic                      taken;

    assign id_ex_ready = ~ex_ls_valid | ex_ls_ready;
    assign accept      = id_ex_valid & id_ex_ready;

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::ALU_SUB:    alu_res = id_ex.operand_a - id_ex.operand_b;
            core_pkg::ALU_AND:    alu_res = id_ex.operand_a & id_ex.operand_b;
            core_pkg::ALU_OR:     alu_res = id_ex.operand_a | id_ex.operand_b;
            core_pkg::ALU_XOR:    alu_res = id_ex.operand_a ^ id_ex.operand_b;
            core_pkg::ALU_PASS_B: alu_res = id_ex.operand_b;
            default:              alu_res = id_ex.operand_a + id_ex.operand_b;
        endcase
    end

    // beq when equal, bne when not
    assign taken = id_ex.is_jal |
                   (id_ex.is_branch & ((id_ex.operand_a == id_ex.operand_b) ^ id_ex.branch_ne));
    assign redirect    = accept & taken;
    assign redirect_pc = id_ex.branch_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ex_ls_valid <= 1'b0;
        else if (accept) ex_ls_valid <= 1'b1;
        else if (ex_ls_ready) ex_ls_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_ls.rd         <= id_ex.rd;
            ex_ls.rd_wen     <= id_ex.rd_wen;
            // link address for jal
            ex_ls.result     <= id_ex.is_jal ? id_ex.pc + 64'd4 : alu_res;
            ex_ls.store_data <= id_ex.store_data;
            ex_ls.is_load    <= id_ex.is_load;
            ex_ls.is_store   <= id_ex.is_store;
        end
    end

endmodule

//--- hdl/idu.sv
`timescale 1ns/1ns

module idu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        if_id_valid,
    output logic                        if_id_ready,
    input  core_pkg::if_id_t            if_id,
    input  logic                        flush,
    output logic [core_pkg::REG_AW-1:0] rs1,
    output logic [core_pkg::REG_AW-1:0] rs2,
    input  logic [core_pkg::XLEN-1:0]   src1,
    input  logic [core_pkg::XLEN-1:0]   src2,
    input  core_pkg::busy_rd_t          ex_busy_rd,
    input  core_pkg::busy_rd_t          ls_busy_rd,
    input  core_pkg::busy_rd_t          wb_busy_rd,
    output logic                        id_ex_valid,
    input  logic                        id_ex_ready,
    output core_pkg::id_ex_t            id_ex
);

    core_pkg::inst_t           inst;
    core_pkg::id_ex_t          dec;
    core_pkg::busy_rd_t        busy [4];
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      stall;
    logic                      accept;

    function automatic logic [2:0] alu_fn(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b100:  return core_pkg::ALU_XOR;
            3'b110:  return core_pkg::ALU_OR;
            3'b111:  return core_pkg::ALU_AND;
            default: return core_pkg::ALU_ADD;
        endcase
    endfunction

    assign inst = if_id.inst;
    assign rs1  = inst.r.rs1;
    assign rs2  = inst.r.rs2;

    // sign extension from the signed operand
    assign imm_i = $signed(inst.i.imm);
    assign imm_s = $signed({inst.r.funct7, inst.r.rd});
    assign imm_b = $signed({inst.r.funct7[6], inst.r.rd[0], inst.r.funct7[5:0],
                            inst.r.rd[4:1], 1'b0});
    assign imm_u = $signed({inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'h0});
    assign imm_j = $signed({inst.r.funct7[6], inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                            inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0});

    always_comb begin
        dec               = '0;
        dec.pc            = if_id.pc;
        dec.rd            = inst.r.rd;
        dec.alu_op        = core_pkg::ALU_ADD;
        dec.operand_a     = src1;
        dec.operand_b     = imm_i;
        dec.store_data    = src2;
        dec.branch_target = if_id.pc + imm_b;
        use_rs1           = 1'b0;
        use_rs2           = 1'b0;
        case (inst.r.opcode)
            core_pkg::OPC_OP: begin
                dec.rd_wen    = 1'b1;
                dec.alu_op    = alu_fn(inst.r.funct3, inst.r.funct7[5]);
                dec.operand_b = src2;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            core_pkg::OPC_OP_IMM: begin
                dec.rd_wen = 1'b1;
                dec.alu_op = alu_fn(inst.i.funct3, 1'b0);
                use_rs1    = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                dec.rd_wen    = 1'b1;
                dec.alu_op    = core_pkg::ALU_PASS_B;
                dec.operand_b = imm_u;
            end
            core_pkg::OPC_LOAD: begin
                dec.rd_wen  = 1'b1;
                dec.is_load = 1'b1;
                use_rs1     = 1'b1;
            end
            core_pkg::OPC_STORE: begin
                dec.is_store  = 1'b1;
                dec.operand_b = imm_s;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                dec.is_branch = 1'b1;
                dec.branch_ne = inst.r.funct3[0];
                dec.operand_b = src2;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            core_pkg::OPC_JAL: begin
                dec.rd_wen        = 1'b1;
                dec.is_jal        = 1'b1;
                dec.branch_target = if_id.pc + imm_j;
            end
            // unknown opcode flows on as a bubble
            default: ;
        endcase
    end

    // ID/EX, EX/LS, pending memory op and LS/WB
    assign busy[0] = '{valid: id_ex_valid, wen: id_ex.rd_wen, rd: id_ex.rd};
    assign busy[1] = ex_busy_rd;
    assign busy[2] = ls_busy_rd;
    assign busy[3] = wb_busy_rd;

    always_comb begin
        stall = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (busy[k].valid && busy[k].wen && busy[k].rd != '0) begin
                if ((use_rs1 && busy[k].rd == rs1) || (use_rs2 && busy[k].rd == rs2)) begin
                    stall = 1'b1;
                end
            end
        end
    end

    assign if_id_ready = ~stall & (~id_ex_valid | id_ex_ready);
    assign accept      = if_id_valid & if_id_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) id_ex_valid <= 1'b0;
        else if (flush) id_ex_valid <= 1'b0;
        else if (accept) id_ex_valid <= 1'b1;
        else if (id_ex_ready) id_ex_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) id_ex <= dec;
    end

endmodule

//--- hdl/ifu.sv
`timescale 1ns/1ns

module ifu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      redirect,
    input  logic [core_pkg::XLEN-1:0] redirect_pc,
    input  logic                      ifu_arready,
    output logic                      ifu_arvalid,
    output logic [core_pkg::XLEN-1:0] ifu_araddr,
    input  logic                      ifu_rvalid,
    output logic                      ifu_rready,
    input  logic [31:0]               ifu_rdata,
    output logic                      if_id_valid,
    input  logic                      if_id_ready,
    output core_pkg::if_id_t          if_id
);

    logic [core_pkg::XLEN-1:0] pc;
    logic                      r_pend;
    logic                      drop;
    logic                      issue;
    logic                      r_fire;
    logic                      load;

    // one fetch at a time and none in a redirect cycle
    assign issue      = ~ifu_arvalid & ~r_pend & ~redirect;
    assign r_fire     = ifu_rvalid & ifu_rready;
    assign load       = r_fire & ~drop & ~redirect;
    assign ifu_rready = r_pend & (drop | ~if_id_valid | if_id_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= core_pkg::RST_PC;
            ifu_arvalid <= 1'b0;
            r_pend      <= 1'b0;
            drop        <= 1'b0;
            if_id_valid <= 1'b0;
        end else begin
            if (issue) ifu_arvalid <= 1'b1;
            else if (ifu_arready) ifu_arvalid <= 1'b0;

            if (ifu_arvalid && ifu_arready) r_pend <= 1'b1;
            else if (r_fire) r_pend <= 1'b0;

            // fetch still on the bus belongs to the old path
            if (redirect && (ifu_arvalid || (r_pend && !r_fire))) drop <= 1'b1;
            else if (r_fire) drop <= 1'b0;

            if (redirect) pc <= redirect_pc;
            else if (load) pc <= pc + 64'd4;

            if (redirect) if_id_valid <= 1'b0;
            else if (load) if_id_valid <= 1'b1;
            else if (if_id_ready) if_id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) ifu_araddr <= pc;
        if (load) begin
            if_id.pc   <= ifu_araddr;
            if_id.inst <= ifu_rdata;
        end
    end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

    localparam int XLEN   = 64;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RST_PC = 64'h0;

    // base opcodes of the kept instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] ALU_ADD    = 3'd0;
    localparam logic [2:0] ALU_SUB    = 3'd1;
    localparam logic [2:0] ALU_AND    = 3'd2;
    localparam logic [2:0] ALU_OR     = 3'd3;
    localparam logic [2:0] ALU_XOR    = 3'd4;
    localparam logic [2:0] ALU_PASS_B = 3'd5;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } inst_i_t;

    // one fetched word, seen through either field layout
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_t           inst;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              rd_wen;
        logic [2:0]        alu_op;
        logic [XLEN-1:0]   operand_a;
        logic [XLEN-1:0]   operand_b;
        logic [XLEN-1:0]   store_data;
        logic              is_load;
        logic              is_store;
        logic              is_branch;
        logic              branch_ne;
        logic              is_jal;
        logic [XLEN-1:0]   branch_target;
    } id_ex_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              rd_wen;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   store_data;
        logic              is_load;
        logic              is_store;
    } ex_ls_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              rd_wen;
        logic [XLEN-1:0]   data;
    } ls_wb_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            write;
    } data_req_t;

    // destination of an instruction still in flight
    typedef struct packed {
        logic              valid;
        logic              wen;
        logic [REG_AW-1:0] rd;
    } busy_rd_t;

endpackage
